//--- source/archPkg.sv
`default_nettype none

package archPkg;

	// Datapath and address width
	localparam int dataW = 16;

	// Register file shape
	localparam int regCount = 4;
	localparam int regIdxW  = 2;

	// Next-PC select codes
	localparam logic [1:0] pcSelNext = 2'b00; // Sequential
	localparam logic [1:0] pcSelImm  = 2'b01; // Payload target
	localparam logic [1:0] pcSelReg  = 2'b10; // Register target

	// First fetch address
	localparam logic [dataW-1:0] resetPc = '0;

endpackage

`default_nettype wire

//--- source/isaPkg.sv
`default_nettype none

package isaPkg;

	// Field widths of one instruction word
	localparam int opcodeW  = 4;
	localparam int aluOpW   = 6;
	localparam int payloadW = 8;

	// Opcodes, all others are no-ops
	localparam logic [opcodeW-1:0] opAlu   = 4'b0000;
	localparam logic [opcodeW-1:0] opLdImm = 4'b0010;
	localparam logic [opcodeW-1:0] opLdInd = 4'b0011;
	localparam logic [opcodeW-1:0] opStInd = 4'b0101;
	localparam logic [opcodeW-1:0] opBrImm = 4'b0110;
	localparam logic [opcodeW-1:0] opBrInd = 4'b0111;

	// ALU operation codes
	localparam logic [aluOpW-1:0] aluAdd = 6'h00;
	localparam logic [aluOpW-1:0] aluSub = 6'h01;
	localparam logic [aluOpW-1:0] aluAnd = 6'h02;
	localparam logic [aluOpW-1:0] aluOr  = 6'h03;
	localparam logic [aluOpW-1:0] aluXor = 6'h04;
	localparam logic [aluOpW-1:0] aluNot = 6'h05;
	localparam logic [aluOpW-1:0] aluShl = 6'h06; // Shift left by one
	localparam logic [aluOpW-1:0] aluShr = 6'h07; // Logical shift right by one
	localparam logic [aluOpW-1:0] aluMov = 6'h08;
	localparam logic [aluOpW-1:0] aluNop = 6'h3F; // Driven for every non-ALU opcode

	// Register view: ALU, loads and stores
	typedef struct packed {
		logic [opcodeW-1:0]         opcode;
		logic [archPkg::regIdxW-1:0] rd;
		logic [archPkg::regIdxW-1:0] rs1;
		logic [archPkg::regIdxW-1:0] rs2;
		logic [aluOpW-1:0]          aluOp;
	} regViewT;

	// Control view: branches and load immediate payload
	typedef struct packed {
		logic [opcodeW-1:0]         opcode;
		logic                       flagSel; // 0 carry, 1 zero
		logic                       flagVal; // Flag value that takes the branch
		logic [archPkg::regIdxW-1:0] rs1;
		logic [payloadW-1:0]        payload;
	} ctrlViewT;

	// Same 16 bits, two decodings
	typedef union packed {
		regViewT  r;
		ctrlViewT c;
	} instrWordT;

endpackage

`default_nettype wire

//--- source/aluUnit.sv
`default_nettype none

module aluUnit
	import isaPkg::*, archPkg::*;
(
	input  logic [aluOpW-1:0] aluOp,
	input  logic [dataW-1:0]  a,      // rs1
	input  logic [dataW-1:0]  b,      // rs2
	output logic [dataW-1:0]  result,
	output logic              carry
);

	logic [dataW:0] sum;
	logic [dataW:0] diff;

	// One extra bit catches carry and borrow
	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		result = '0;
		carry  = 1'b0;

		case (aluOp)
			aluAdd: begin
				result = sum[dataW-1:0];
				carry  = sum[dataW];
			end
			aluSub: begin
				result = diff[dataW-1:0];
				carry  = diff[dataW]; // Set on borrow
			end
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluXor: result = a ^ b;
			aluNot: result = ~a;
			aluShl: begin
				result = {a[dataW-2:0], 1'b0};
				carry  = a[dataW-1];    // Bit shifted out at the top
			end
			aluShr: begin
				result = {1'b0, a[dataW-1:1]};
				carry  = a[0];
			end
			aluMov: result = a;

			// Undefined codes give zero, carry clear
			default: begin
				result = '0;
				carry  = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/decoder.sv
`default_nettype none

module decoder
	import isaPkg::*, archPkg::*;
(
	input  logic [dataW-1:0]   instruction,

	input  logic               cFlag,           // Branch condition sources
	input  logic               zFlag,
	output logic [1:0]         nextPCSel,       // Sequential, payload or rs1 target

	output logic               regDataInSource, // Write back from data memory
	output logic               immData,         // Write back from payload
	output logic [regIdxW-1:0] regDst,
	output logic               regFileWE,
	output logic [regIdxW-1:0] regSrc1,
	output logic [regIdxW-1:0] regSrc2,

	output logic [aluOpW-1:0]  aluOp,

	output logic               memWE,
	output logic               dAddrSel,        // Address from rs1
	output logic [dataW-1:0]   instrData        // Zero-extended payload
);

	instrWordT          word;
	logic [dataW-1:0]   payloadExt;
	logic               brFlag;
	logic               brTaken;

	assign word = instruction;

	// Register fields are always split out, controls below keep unused ones harmless
	assign regDst  = word.r.rd;
	assign regSrc1 = word.r.rs1;
	assign regSrc2 = word.r.rs2;

	assign payloadExt = {{(dataW-payloadW){1'b0}}, word.c.payload};

	// Branch condition
	assign brFlag  = word.c.flagSel ? zFlag : cFlag;
	assign brTaken = (brFlag == word.c.flagVal);

	always_comb begin
		nextPCSel       = pcSelNext;
		regDataInSource = 1'b0;
		immData         = 1'b0;
		regFileWE       = 1'b0;
		aluOp           = aluNop; // Keeps flags untouched outside ALU ops
		memWE           = 1'b0;
		dAddrSel        = 1'b0;
		instrData       = '0;

		case (word.r.opcode)
			opAlu: begin
				regFileWE = 1'b1;
				aluOp     = word.r.aluOp;
			end

			opLdImm: begin
				immData   = 1'b1;
				regFileWE = 1'b1;
				instrData = payloadExt;
			end

			opLdInd: begin
				dAddrSel        = 1'b1; // rs1 holds the address
				regDataInSource = 1'b1;
				regFileWE       = 1'b1;
			end

			opStInd: begin
				dAddrSel = 1'b1;
				memWE    = 1'b1; // rs2 is the store data
			end

			opBrImm: begin
				if (brTaken) begin
					nextPCSel = pcSelImm;
					instrData = payloadExt;
				end
			end

			opBrInd: begin
				if (brTaken) begin
					nextPCSel = pcSelReg;
				end
			end

			// Unused opcodes fall through as no-ops
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/execUnit.sv
`default_nettype none

module execUnit
	import isaPkg::*, archPkg::*;
(
	input  logic               clk,
	input  logic               rstN,

	input  logic [regIdxW-1:0] regDst,
	input  logic [regIdxW-1:0] regSrc1,
	input  logic [regIdxW-1:0] regSrc2,
	input  logic               regFileWE,
	input  logic [aluOpW-1:0]  aluOp,
	input  logic               memWE,
	input  logic               dAddrSel,
	input  logic [dataW-1:0]   instrData,
	input  logic [dataW-1:0]   regWData,   // Selected write-back value

	output logic [dataW-1:0]   rs1Data,
	output logic [dataW-1:0]   aluResult,
	output logic               cFlag,
	output logic               zFlag,

	output logic [dataW-1:0]   dAddr,
	output logic [dataW-1:0]   dWData,
	output logic               memWrEn
);

	logic [dataW-1:0] regFile [regCount];
	logic [dataW-1:0] rs2Data;
	logic             aluCarry;
	logic             flagWE;

	// Asynchronous read ports
	assign rs1Data = regFile[regSrc1];
	assign rs2Data = regFile[regSrc2];

	aluUnit alu_i (
		.aluOp  (aluOp),
		.a      (rs1Data),
		.b      (rs2Data),
		.result (aluResult),
		.carry  (aluCarry)
	);

	// Only a real ALU code marks an ALU op, the decoder forces aluNop otherwise
	assign flagWE = regFileWE &&
		(aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNot, aluShl, aluShr, aluMov});

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else begin
			if (regFileWE) begin
				regFile[regDst] <= regWData;
			end
			if (flagWE) begin
				cFlag <= aluCarry;
				zFlag <= (aluResult == '0); // Zero from the result itself
			end
		end
	end

	// Data port
	assign dAddr   = dAddrSel ? rs1Data : instrData;
	assign dWData  = rs2Data;
	assign memWrEn = memWE & rstN; // No stray writes in reset

endmodule

`default_nettype wire

//--- source/flowControl.sv
`default_nettype none

module flowControl
	import archPkg::*;
(
	input  logic             clk,
	input  logic             rstN,

	input  logic [1:0]       nextPCSel,
	input  logic             immData,
	input  logic             regDataInSource,
	input  logic [dataW-1:0] instrData,       // Payload target or load value
	input  logic [dataW-1:0] rs1Data,         // Indirect branch target
	input  logic [dataW-1:0] aluResult,
	input  logic [dataW-1:0] dRData,

	output logic [dataW-1:0] pc,
	output logic [dataW-1:0] regWData
);

	logic [dataW-1:0] pcNext;

	// Next PC mux
	always_comb begin
		case (nextPCSel)
			pcSelImm: pcNext = instrData;
			pcSelReg: pcNext = rs1Data;
			default:  pcNext = pc + 1'b1; // Sequential and untaken branches
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetPc;
		end else begin
			pc <= pcNext;
		end
	end

	// Write-back source, payload first then memory then ALU
	always_comb begin
		if (immData) begin
			regWData = instrData;
		end else if (regDataInSource) begin
			regWData = dRData;
		end else begin
			regWData = aluResult;
		end
	end

endmodule

`default_nettype wire

//--- source/cpuTop.sv
`default_nettype none

module cpuTop
	import isaPkg::*, archPkg::*;
(
	input  logic             clk,
	input  logic             rstN,

	// Fetch port
	output logic [dataW-1:0] instrAddr,
	input  logic [dataW-1:0] instruction,

	// Data port
	output logic [dataW-1:0] dAddr,
	output logic [dataW-1:0] dWData,
	output logic             memWrEn,
	input  logic [dataW-1:0] dRData
);

	logic [1:0]         nextPCSel;
	logic               regDataInSource;
	logic               immData;
	logic               regFileWE;
	logic [regIdxW-1:0] regDst;
	logic [regIdxW-1:0] regSrc1;
	logic [regIdxW-1:0] regSrc2;
	logic [aluOpW-1:0]  aluOp;
	logic               memWE;
	logic               dAddrSel;
	logic [dataW-1:0]   instrData;
	logic               cFlag;
	logic               zFlag;
	logic [dataW-1:0]   rs1Data;
	logic [dataW-1:0]   aluResult;
	logic [dataW-1:0]   regWData;

	decoder decoder_i (
		.instruction(instruction), .cFlag(cFlag), .zFlag(zFlag),
		.nextPCSel(nextPCSel), .regDataInSource(regDataInSource), .immData(immData),
		.regDst(regDst), .regFileWE(regFileWE), .regSrc1(regSrc1), .regSrc2(regSrc2),
		.aluOp(aluOp), .memWE(memWE), .dAddrSel(dAddrSel), .instrData(instrData)
	);

	execUnit execUnit_i (
		.clk(clk), .rstN(rstN), .regDst(regDst), .regSrc1(regSrc1), .regSrc2(regSrc2),
		.regFileWE(regFileWE), .aluOp(aluOp), .memWE(memWE), .dAddrSel(dAddrSel),
		.instrData(instrData), .regWData(regWData), .rs1Data(rs1Data),
		.aluResult(aluResult), .cFlag(cFlag), .zFlag(zFlag),
		.dAddr(dAddr), .dWData(dWData), .memWrEn(memWrEn)
	);

	flowControl flowControl_i (
		.clk(clk), .rstN(rstN), .nextPCSel(nextPCSel), .immData(immData),
		.regDataInSource(regDataInSource), .instrData(instrData), .rs1Data(rs1Data),
		.aluResult(aluResult), .dRData(dRData), .pc(instrAddr), .regWData(regWData)
	);

endmodule

`default_nettype wire

//--- sim/cpuChk.sv
`default_nettype none

module cpuChk
	import isaPkg::*, archPkg::*;
(
	input logic             clk,
	input logic             rstN,
	input logic [dataW-1:0] instrAddr,
	input logic [dataW-1:0] instruction,
	input logic [dataW-1:0] regWData,
	input logic [dataW-1:0] rs1Data,
	input logic [dataW-1:0] dAddr,
	input logic [dataW-1:0] dRData,
	input logic             memWrEn,
	input logic             immData,
	input logic             regDataInSource,
	input logic             cFlag,
	input logic             zFlag
);
	timeunit 1ns;
	timeprecision 100ps;

	instrWordT        word;
	logic             isBr;
	logic             brTaken;
	logic [dataW-1:0] brTarget;

	assign word    = instruction;
	assign isBr    = (word.c.opcode == opBrImm) || (word.c.opcode == opBrInd);
	assign brTaken = ((word.c.flagSel ? zFlag : cFlag) == word.c.flagVal);

	// Where the PC must go after this fetch
	always_comb begin
		if (!brTaken) begin
			brTarget = instrAddr + 16'd1;
		end else if (word.c.opcode == opBrImm) begin
			brTarget = {8'h00, word.c.payload};
		end else begin
			brTarget = rs1Data;
		end
	end

	noWriteInReset: assert property (@(posedge clk) !rstN |-> !memWrEn)
		else $error("memory write strobe high during reset");

	pcAfterReset: assert property (@(posedge clk) $rose(rstN) |-> instrAddr == resetPc)
		else $error("first fetch after reset not at the reset address");

	ldImmValue: assert property (@(posedge clk) disable iff (!rstN)
		immData |-> regWData == {8'h00, word.c.payload})
		else $error("load immediate writes a value other than its payload");

	branchTarget: assert property (@(posedge clk) disable iff (!rstN)
		isBr |=> instrAddr == $past(brTarget))
		else $error("PC after a branch is wrong");

	loadPath: assert property (@(posedge clk) disable iff (!rstN)
		regDataInSource |-> (regWData == dRData) && (dAddr == rs1Data))
		else $error("indirect load uses a wrong address or value");

	storeAddr: assert property (@(posedge clk) memWrEn |-> dAddr == rs1Data)
		else $error("store address is not the rs1 value");

endmodule

bind cpuTop cpuChk chk_i (
	.clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instruction(instruction),
	.regWData(regWData), .rs1Data(rs1Data), .dAddr(dAddr), .dRData(dRData),
	.memWrEn(memWrEn), .immData(immData), .regDataInSource(regDataInSource),
	.cFlag(cFlag), .zFlag(zFlag)
);

`default_nettype wire

//--- sim/tbTop.sv
`default_nettype none

module tbTop
	import isaPkg::*, archPkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCyc = 4;
	localparam int lenReset = 6;
	localparam int lenLdImm = 10;
	localparam int lenAlu   = 60;
	localparam int lenBr    = 100;
	localparam int lenMem   = 20;
	localparam int cycLimit = lenReset + lenLdImm + lenAlu + lenBr + lenMem
		+ 5 * (resetCyc + 1) + 100;

	logic             clk;
	logic             rstN;
	logic [15:0]      instrAddr;
	logic [15:0]      instruction;
	logic [15:0]      dAddr;
	logic [15:0]      dWData;
	logic [15:0]      dRData;
	logic             memWrEn;

	logic [15:0] rom [256];
	logic [15:0] ram [256];
	int          pcW;             // Next free ROM slot
	logic [7:0]  expA [$];        // Expected RAM address and value
	logic [15:0] expV [$];
	int          cycles  = 0;
	int          passCnt = 0;
	int          failCnt = 0;

	cpuTop dut_i (
		.clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instruction(instruction),
		.dAddr(dAddr), .dWData(dWData), .memWrEn(memWrEn), .dRData(dRData)
	);

	// Both memories answer in the same cycle
	assign instruction = rom[instrAddr[7:0]];
	assign dRData      = ram[dAddr[7:0]];

	always @(posedge clk) begin
		if (memWrEn) ram[dAddr[7:0]] <= dWData;
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycLimit) begin
			$display("Timeout: simulation ran past %0d cycles", cycLimit);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [15:0] fillWord(logic [7:0] a);
		return {~a, a}; // Untouched RAM words
	endfunction

	function automatic logic [15:0] encReg(logic [3:0] op, logic [1:0] rd, logic [1:0] rs1,
		logic [1:0] rs2, logic [5:0] aop);
		return {op, rd, rs1, rs2, aop};
	endfunction

	function automatic logic [15:0] encCtl(logic [3:0] op, logic sel, logic val, logic [1:0] rs1,
		logic [7:0] payload);
		return {op, sel, val, rs1, payload};
	endfunction

	task automatic emit(logic [15:0] w);
		rom[pcW] = w;
		pcW++;
	endtask

	task automatic ldi(logic [1:0] rd, logic [7:0] v);
		emit(encReg(opLdImm, rd, 2'd0, 2'd0, 6'd0) | {8'h00, v});
	endtask

	task automatic st(logic [1:0] ra, logic [1:0] rv);
		emit(encReg(opStInd, 2'd0, ra, rv, 6'd0));
	endtask

	task automatic expectWord(logic [7:0] a, logic [15:0] v);
		expA.push_back(a);
		expV.push_back(v);
	endtask

	// Blank ROM of no-ops and patterned RAM
	task automatic clearMem();
		for (int i = 0; i < 256; i++) begin
			rom[i] = 16'h1000;
			ram[i] = fillWord(8'(i));
		end
		pcW = 0;
		expA.delete();
		expV.delete();
	endtask

	task automatic resetCore();
		rstN = 1'b0;
		repeat (resetCyc) @(posedge clk);
		#0.5 rstN = 1'b1;
	endtask

	task automatic runCheck(string name, int len);
		int errs;
		errs = 0;
		resetCore();
		if (instrAddr !== 16'h0000) begin
			$display("FAILED at %0t: %s PC is %h after reset", $time, name, instrAddr);
			errs++;
		end
		repeat (len) @(posedge clk);
		#0.5;
		foreach (expA[i]) begin
			if (ram[expA[i]] !== expV[i]) begin
				$display("FAILED at %0t: %s RAM[%h] is %h, expected %h", $time, name,
					expA[i], ram[expA[i]], expV[i]);
				errs++;
			end
		end
		if (errs == 0) passCnt++;
		else failCnt++;
		$display("%s: %s", name, (errs == 0) ? "ok" : "error");
	endtask

	// One ALU op, its stored result, and a carry check that skips the bad store
	task automatic aluStep(logic [5:0] aop, logic [1:0] rd, logic [1:0] rs1, logic [1:0] rs2,
		logic [7:0] slot, logic [15:0] res, logic cExp);
		emit(encReg(opAlu, rd, rs1, rs2, aop));
		ldi(2'd3, slot);
		st(2'd3, rd);
		emit(encCtl(opBrImm, 1'b0, cExp, 2'd0, 8'(pcW + 2)));
		st(2'd3, 2'd3);                             // Only on a wrong carry
		expectWord(slot, res);
	endtask

	initial begin
		logic [7:0]  ra;
		logic [7:0]  rb;
		logic [15:0] a16;
		logic [15:0] b16;
		logic [15:0] na;
		logic [16:0] wide;
		logic [15:0] peek;
		logic        cNow;
		logic        zNow;
		logic        taken;
		logic [7:0]  slot;
		logic [7:0]  tgt;

		rstN = 1'b0;
		void'($urandom(32'hfe8e973e));
		clearMem();

		// Reset holds off a store sitting at address 0
		st(2'd0, 2'd0);
		runCheck("reset", lenReset);

		clearMem();
		ra = 8'($urandom());
		ldi(2'd0, ra);
		ldi(2'd3, 8'h80);
		st(2'd3, 2'd0);
		expectWord(8'h80, {8'h00, ra});
		runCheck("load immediate", lenLdImm);

		clearMem();
		ra  = 8'($urandom());
		rb  = 8'($urandom());
		a16 = {8'h00, ra};
		b16 = {8'h00, rb};
		na  = ~a16;
		ldi(2'd0, ra);
		ldi(2'd1, rb);
		aluStep(aluNot, 2'd0, 2'd0, 2'd0, 8'h80, na, 1'b0);
		wide = {1'b0, na} + {1'b0, na};              // Overflows since the top byte is all ones
		aluStep(aluAdd, 2'd2, 2'd0, 2'd0, 8'h81, wide[15:0], wide[16]);
		wide = {1'b0, b16} - {1'b0, na};
		aluStep(aluSub, 2'd2, 2'd1, 2'd0, 8'h82, wide[15:0], wide[16]);
		aluStep(aluAnd, 2'd2, 2'd0, 2'd1, 8'h83, na & b16, 1'b0);
		aluStep(aluOr,  2'd2, 2'd0, 2'd1, 8'h84, na | b16, 1'b0);
		aluStep(aluXor, 2'd2, 2'd0, 2'd1, 8'h85, na ^ b16, 1'b0);
		aluStep(aluShl, 2'd2, 2'd0, 2'd0, 8'h86, {na[14:0], 1'b0}, na[15]);
		aluStep(aluShr, 2'd2, 2'd1, 2'd0, 8'h87, {1'b0, b16[15:1]}, b16[0]);
		aluStep(aluMov, 2'd2, 2'd1, 2'd0, 8'h88, b16, 1'b0);
		runCheck("alu", lenAlu);

		clearMem();
		ldi(2'd0, 8'h00);
		slot = 8'hC0;
		for (int s = 0; s < 2; s++) begin
			if (s == 0) begin
				emit(encReg(opAlu, 2'd2, 2'd0, 2'd0, aluAdd)); // Zero set and carry clear
				cNow = 1'b0;
				zNow = 1'b1;
			end else begin
				emit(encReg(opAlu, 2'd2, 2'd0, 2'd0, aluNot));
				emit(encReg(opAlu, 2'd2, 2'd2, 2'd2, aluAdd)); // Carry set and zero clear
				cNow = 1'b1;
				zNow = 1'b0;
			end
			for (int k = 0; k < 8; k++) begin
				taken = ((k[2] ? zNow : cNow) == k[1]);
				if (k[0]) begin
					tgt = 8'(pcW + 4);
					ldi(2'd1, tgt);
					ldi(2'd3, slot);
					emit(encCtl(opBrInd, k[2], k[1], 2'd1, 8'h00));
				end else begin
					tgt = 8'(pcW + 3);
					ldi(2'd3, slot);
					emit(encCtl(opBrImm, k[2], k[1], 2'd0, tgt));
				end
				st(2'd3, 2'd3);                          // Fall-through marker
				expectWord(slot, taken ? fillWord(slot) : {8'h00, slot});
				slot++;
			end
		end
		runCheck("branch", lenBr);

		clearMem();
		ra   = 8'($urandom());
		peek = 16'($urandom());
		ram[8'h50] = peek;
		ldi(2'd0, ra);
		ldi(2'd3, 8'h40);
		st(2'd3, 2'd0);
		emit(encReg(opLdInd, 2'd2, 2'd3, 2'd0, 6'd0)); // Read back what was stored
		ldi(2'd3, 8'h41);
		st(2'd3, 2'd2);
		ldi(2'd1, 8'h50);
		emit(encReg(opLdInd, 2'd2, 2'd1, 2'd0, 6'd0));
		ldi(2'd3, 8'h51);
		st(2'd3, 2'd2);
		ldi(2'd3, 8'h53);                               // rs1 of the no-op points at 0x53
		emit(encReg(4'b0100, 2'd2, 2'd3, 2'd2, aluAdd)); // Unused opcode
		ldi(2'd3, 8'h52);
		st(2'd3, 2'd2);
		expectWord(8'h40, {8'h00, ra});
		expectWord(8'h41, {8'h00, ra});
		expectWord(8'h51, peek);
		expectWord(8'h52, peek);
		expectWord(8'h53, fillWord(8'h53));
		runCheck("memory", lenMem);

		$display("Tests: %0d ok, %0d with errors", passCnt, failCnt);
		if (failCnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
source/archPkg.sv
source/isaPkg.sv
source/aluUnit.sv
source/decoder.sv
source/execUnit.sv
source/flowControl.sv
source/cpuTop.sv
sim/cpuChk.sv
sim/tbTop.sv

//--- run.sh
#!/bin/sh
# Build and run the regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tbTop -f build.f -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "^Regression passed$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
